// File: Bender.yml
package:
  name: polymul

sources:
  - verilog/polymul_pkg.sv
  - verilog/gf_mul.sv
  - verilog/gf_mac_array.sv
  - verilog/polymul_mem.sv
  - verilog/polymul_seq.sv
  - verilog/polymul_wb_slave.sv
  - verilog/polymul_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/polymul_tb.sv

// File: all.f
verilog/polymul_pkg.sv
verilog/gf_mul.sv
verilog/gf_mac_array.sv
verilog/polymul_mem.sv
verilog/polymul_seq.sv
verilog/polymul_wb_slave.sv
verilog/polymul_top.sv
tests/tb_clock.sv
tests/polymul_tb.sv

// File: tests/polymul_tb.sv
module polymul_tb;

	import polymul_pkg::*;

	localparam int N_COEF = COEFS * DEPTH;  // coefficients per polynomial
	localparam int RUNS = 3;
	localparam int CYCLE_LIMIT = RUNS * (STEPS + 10) + 3 * DEPTH * 3 * RUNS + 300;

	logic clk;
	logic rst_b;
	wb_req_t req;
	wb_rsp_t rsp;

	integer seed;
	int errors;
	int tests_pass;
	int tests_fail;
	int cycles;

	poly_word_u a_w [DEPTH];
	poly_word_u b_w [DEPTH];
	poly_word_u exp_c [DEPTH];

	tb_clock u_clk (.clk(clk));

	polymul_top uut (
		.clk(clk),
		.rst_b(rst_b),
		.req(req),
		.rsp(rsp)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles, stopped by timeout", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic coef_t field_mul(input coef_t x, input coef_t y);
		logic [2*GF_M-2:0] wide;
		logic [2*GF_M-2:0] xs;
		logic [2*GF_M-2:0] poly;
		wide = '0;
		xs = x;
		poly = {1'b1, FIELD_POLY};
		for (int i = 0; i < GF_M; i++)
			if (y[i])
				wide = wide ^ (xs << i);  // carry-less product
		// fold down from the top bit
		for (int i = 2*GF_M-2; i >= GF_M; i--)
			if (wide[i])
				wide = wide ^ (poly << (i - GF_M));
		return wide[GF_M-1:0];
	endfunction

	// c = a*b mod (z^N - 1)
	task automatic convolve();
		coef_t c [N_COEF];
		for (int n = 0; n < N_COEF; n++)
			c[n] = '0;
		for (int i = 0; i < N_COEF; i++)
			for (int j = 0; j < N_COEF; j++)
				c[(i + j) % N_COEF] = c[(i + j) % N_COEF]
					^ field_mul(a_w[i / COEFS].coef[i % COEFS], b_w[j / COEFS].coef[j % COEFS]);
		for (int n = 0; n < N_COEF; n++)
			exp_c[n / COEFS].coef[n % COEFS] = c[n];
	endtask

	function automatic logic [WORD_W-1:0] rand_word();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[WORD_W-1:0];
	endfunction

	// ----------------------------------------
	// bus tasks, entered 1 unit after an edge
	// ----------------------------------------
	task automatic bus_transfer(input logic we, input logic [BUS_ADR_W-1:0] adr,
			input logic [WORD_W-1:0] wdat, output logic [WORD_W-1:0] rdat);
		int waited;
		logic got;
		got = 1'b0;
		waited = 0;
		rdat = '0;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		while (!got && waited < 4) begin
			@(posedge clk);
			#1;
			waited++;
			if (rsp.ack) begin
				got = 1'b1;
				rdat = rsp.dat;
			end
		end
		req.cyc = 1'b0;
		req.stb = 1'b0;
		req.we = 1'b0;
		if (!got) begin
			$display("no ack from the DUT within 4 cycles for address %h", adr);
			errors++;
		end else begin
			@(posedge clk);
			#1;
			if (rsp.ack) begin  // ack must be a single cycle
				$display("DUT acked address %h a second time", adr);
				errors++;
			end
		end
	endtask

	task automatic write_word(input logic [1:0] region, input int idx,
			input logic [WORD_W-1:0] dat);
		logic [WORD_W-1:0] unused;
		bus_transfer(1'b1, {region, ADDR_W'(idx)}, dat, unused);
	endtask

	task automatic read_word(input logic [1:0] region, input int idx,
			output logic [WORD_W-1:0] dat);
		bus_transfer(1'b0, {region, ADDR_W'(idx)}, '0, dat);
	endtask

	task automatic load_random_operands();
		for (int w = 0; w < DEPTH; w++) begin
			a_w[w].raw = rand_word();
			write_word(REGION_A, w, a_w[w].raw);
		end
		for (int w = 0; w < DEPTH; w++) begin
			b_w[w].raw = rand_word();
			write_word(REGION_B, w, b_w[w].raw);
		end
	endtask

	// poll status until the run is over
	task automatic wait_run();
		logic [WORD_W-1:0] st;
		st = '0;
		while (!(st[STAT_DONE] && !st[STAT_BUSY]))
			read_word(REGION_CTRL, 0, st);
	endtask

	task automatic check_c();
		logic [WORD_W-1:0] got;
		for (int w = 0; w < DEPTH; w++) begin
			read_word(REGION_C, w, got);
			if (got !== exp_c[w].raw) begin
				$display("error at %0t: C[%0d] is %h, expected %h", $time, w, got, exp_c[w].raw);
				errors++;
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		if (errors == mark) begin
			tests_pass++;
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_fail++;
			$display("test %0d %s: fail, %0d errors", num, name, errors - mark);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int mark;
		int k;
		int src;
		logic [WORD_W-1:0] rd;
		poly_word_u spare;
		seed = 28438;
		errors = 0;
		tests_pass = 0;
		tests_fail = 0;
		cycles = 0;
		req = '0;
		rst_b = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_b = 1'b1;

		mark = errors;
		if (rsp.ack) begin
			$display("error at %0t: ack high after reset", $time);
			errors++;
		end
		read_word(REGION_CTRL, 0, rd);
		if (rd[STAT_BUSY] !== 1'b0 || rd[STAT_DONE] !== 1'b0) begin
			$display("error at %0t: status after reset is %h, expected busy and done low",
				$time, rd);
			errors++;
		end
		report_test(1, "reset status", mark);

		mark = errors;
		load_random_operands();
		for (int w = 0; w < DEPTH; w++) begin
			read_word(REGION_A, w, rd);
			if (rd !== a_w[w].raw) begin
				$display("error at %0t: A[%0d] reads %h, expected %h", $time, w, rd, a_w[w].raw);
				errors++;
			end
			read_word(REGION_B, w, rd);
			if (rd !== '0) begin
				$display("error at %0t: B[%0d] reads %h, expected zero", $time, w, rd);
				errors++;
			end
		end
		report_test(2, "A readback and B reads zero", mark);

		// operands from the previous test
		mark = errors;
		write_word(REGION_CTRL, 0, '0);
		wait_run();
		convolve();
		check_c();
		report_test(3, "random convolution", mark);

		// A = z^k rotates B up by k
		mark = errors;
		k = $unsigned($random(seed)) % N_COEF;
		for (int w = 0; w < DEPTH; w++)
			a_w[w].raw = '0;
		a_w[k / COEFS].coef[k % COEFS] = coef_t'(1);
		for (int w = 0; w < DEPTH; w++) begin
			write_word(REGION_A, w, a_w[w].raw);
			b_w[w].raw = rand_word();
			write_word(REGION_B, w, b_w[w].raw);
		end
		write_word(REGION_CTRL, 0, '0);
		wait_run();
		for (int n = 0; n < N_COEF; n++) begin
			src = (n - k + N_COEF) % N_COEF;
			exp_c[n / COEFS].coef[n % COEFS] = b_w[src / COEFS].coef[src % COEFS];
		end
		check_c();
		report_test(4, "monomial rotation", mark);

		// second run, host writes while busy must be dropped
		mark = errors;
		load_random_operands();
		write_word(REGION_CTRL, 0, '0);
		spare.raw = rand_word();
		write_word(REGION_A, 0, spare.raw);
		write_word(REGION_CTRL, 0, '0);
		read_word(REGION_CTRL, 0, rd);
		if (rd[STAT_BUSY] !== 1'b1 || rd[STAT_DONE] !== 1'b0) begin
			$display("error at %0t: status during run is %h, expected busy only", $time, rd);
			errors++;
		end
		wait_run();
		convolve();
		check_c();
		read_word(REGION_A, 0, rd);
		if (rd !== a_w[0].raw) begin
			$display("error at %0t: A[0] reads %h after a busy write, expected %h",
				$time, rd, a_w[0].raw);
			errors++;
		end
		report_test(5, "second run with busy writes", mark);

		$display("tests passed %0d failed %0d, check errors %0d", tests_pass, tests_fail, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #2 clk = ~clk;  // period 4

endmodule

// File: verilog/gf_mac_array.sv
module gf_mac_array (
	input polymul_pkg::poly_word_u a_word,
	input polymul_pkg::poly_word_u b_hi,
	input polymul_pkg::poly_word_u b_lo,
	output polymul_pkg::poly_word_u prod
);

	import polymul_pkg::*;

	// ten-coefficient window, b_lo below b_hi
	coef_t [2*COEFS-1:0] win;

	// partial products, [output coef][a coef]
	coef_t pp [COEFS][COEFS];

	assign win = {b_hi.coef, b_lo.coef};

	// ----------------------------------------
	// 5x5 multiplier grid
	// ----------------------------------------
	for (genvar gr = 0; gr < COEFS; gr++) begin : g_row
		for (genvar ga = 0; ga < COEFS; ga++) begin : g_col
			// a coef ga pairs with window slot 5+gr-ga, always 1..9
			gf_mul u_mul (
				.a(a_word.coef[ga]),
				.b(win[COEFS + gr - ga]),
				.p(pp[gr][ga])
			);
		end
	end

	// ----------------------------------------
	// xor trees, one per output coefficient
	// ----------------------------------------
	always_comb begin
		for (int r = 0; r < COEFS; r++) begin
			prod.coef[r] = '0;
			for (int k = 0; k < COEFS; k++)
				prod.coef[r] = prod.coef[r] ^ pp[r][k];
		end
	end

endmodule

// File: verilog/gf_mul.sv
module gf_mul (
	input polymul_pkg::coef_t a,
	input polymul_pkg::coef_t b,
	output polymul_pkg::coef_t p
);

	import polymul_pkg::*;

	// shift and add, one bit of b per pass
	always_comb begin : mul_loop
		coef_t acc;
		coef_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			// multiply sh by x, fold the overflow back in
			if (sh[GF_M-1])
				sh = {sh[GF_M-2:0], 1'b0} ^ FIELD_POLY;
			else
				sh = {sh[GF_M-2:0], 1'b0};
		end
		p = acc;
	end

endmodule

// File: verilog/polymul_mem.sv
module polymul_mem (
	input logic clk,
	input polymul_pkg::mem_wr_t wr,
	input logic [polymul_pkg::ADDR_W-1:0] raddr0,
	output polymul_pkg::poly_word_u rdata0,
	input logic [polymul_pkg::ADDR_W-1:0] raddr1,
	output polymul_pkg::poly_word_u rdata1
);

	import polymul_pkg::*;

	poly_word_u mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// both read ports are asynchronous
	assign rdata0 = mem[raddr0];
	assign rdata1 = mem[raddr1];

endmodule

// File: verilog/polymul_pkg.sv
package polymul_pkg;

	// ----------------------------------------
	// field and word geometry
	// ----------------------------------------
	localparam int GF_M = 8;                          // bits per coefficient
	localparam logic [GF_M-1:0] FIELD_POLY = 8'h1B;  // x^8+x^4+x^3+x+1, top bit implied
	localparam int COEFS = 5;                         // coefficients per word
	localparam int DEPTH = 8;                         // words per memory, power of two
	localparam int ADDR_W = 3;
	localparam int WORD_W = COEFS * GF_M;
	localparam int STEPS = DEPTH * DEPTH;             // word products per run

	// ----------------------------------------
	// bus address map
	// ----------------------------------------
	localparam int BUS_ADR_W = 5;                     // [4:3] region, [2:0] word
	localparam logic [1:0] REGION_A = 2'd0;
	localparam logic [1:0] REGION_B = 2'd1;
	localparam logic [1:0] REGION_C = 2'd2;
	localparam logic [1:0] REGION_CTRL = 2'd3;

	localparam int STAT_BUSY = 0;                     // status word bits
	localparam int STAT_DONE = 1;

	typedef logic [GF_M-1:0] coef_t;

	// same word, bus view or per-coefficient view; coef[0] in the low bits
	typedef union packed {
		logic [WORD_W-1:0] raw;
		coef_t [COEFS-1:0] coef;
	} poly_word_u;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [BUS_ADR_W-1:0] adr;
		logic [WORD_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WORD_W-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic en;
		logic [ADDR_W-1:0] addr;
		poly_word_u data;
	} mem_wr_t;

endpackage

// File: verilog/polymul_seq.sv
module polymul_seq (
	input logic clk,
	input logic rst_b,
	input logic start,
	output logic busy,
	output logic finish,
	output logic [polymul_pkg::ADDR_W-1:0] a_addr,
	output logic [polymul_pkg::ADDR_W-1:0] b_hi_addr,
	output logic [polymul_pkg::ADDR_W-1:0] b_lo_addr,
	output logic [polymul_pkg::ADDR_W-1:0] c_raddr,
	input polymul_pkg::poly_word_u a_data,
	input polymul_pkg::poly_word_u b_hi_data,
	input polymul_pkg::poly_word_u b_lo_data,
	input polymul_pkg::poly_word_u c_rdata,
	output polymul_pkg::mem_wr_t c_wr
);

	import polymul_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN   // last product still in the pipe
	} state_t;

	state_t state;
	logic [ADDR_W-1:0] p;          // A word, outer loop
	logic [ADDR_W-1:0] q;          // C word, inner loop
	logic go;
	poly_word_u prod;

	// product pipeline stage
	logic pipe_vld;
	logic pipe_first;              // p was 0, overwrite C
	logic [ADDR_W-1:0] pipe_q;
	poly_word_u pipe_prod;

	assign go = (state == IDLE) & start & ~busy;

	// ----------------------------------------
	// step counters and run control
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state <= IDLE;
			p <= '0;
			q <= '0;
			busy <= 1'b0;
			finish <= 1'b0;
			pipe_vld <= 1'b0;
			pipe_first <= 1'b0;
			pipe_q <= '0;
		end else begin
			finish <= 1'b0;
			case (state)
				IDLE: if (go) begin
					state <= RUN;
					p <= '0;
					q <= '0;
				end
				RUN: begin
					q <= q + 1'b1;
					if (&q) begin  // q wraps, DEPTH is a power of two
						p <= p + 1'b1;
						if (&p)
							state <= DRAIN;
					end
				end
				DRAIN: begin
					state <= IDLE;
					finish <= 1'b1;
				end
				default: state <= IDLE;
			endcase

			if (finish)
				busy <= 1'b0;
			else if (go)
				busy <= 1'b1;

			pipe_vld <= (state == RUN);
			pipe_first <= (p == '0);
			pipe_q <= q;
		end
	end

	always_ff @(posedge clk)
		pipe_prod <= prod;

	// window B[q-p-1], B[q-p], indices wrap mod DEPTH
	assign a_addr = p;
	assign b_hi_addr = q - p;
	assign b_lo_addr = q - p - 1'b1;

	gf_mac_array u_mac (
		.a_word(a_data),
		.b_hi(b_hi_data),
		.b_lo(b_lo_data),
		.prod(prod)
	);

	// ----------------------------------------
	// C read-modify-write
	// ----------------------------------------
	assign c_raddr = pipe_q;

	always_comb begin
		c_wr.en = pipe_vld;
		c_wr.addr = pipe_q;
		if (pipe_first)
			c_wr.data.raw = pipe_prod.raw;
		else
			c_wr.data.raw = pipe_prod.raw ^ c_rdata.raw;  // accumulate
	end

endmodule

// File: verilog/polymul_top.sv
module polymul_top (
	input logic clk,
	input logic rst_b,
	input polymul_pkg::wb_req_t req,
	output polymul_pkg::wb_rsp_t rsp
);

	import polymul_pkg::*;

	// host side
	mem_wr_t a_wr;
	mem_wr_t b_wr;
	logic [ADDR_W-1:0] host_raddr;
	poly_word_u host_a_rdata;
	poly_word_u host_c_rdata;
	logic start;
	logic busy;
	logic finish;

	// sequencer side
	logic [ADDR_W-1:0] a_addr;
	logic [ADDR_W-1:0] b_hi_addr;
	logic [ADDR_W-1:0] b_lo_addr;
	logic [ADDR_W-1:0] c_raddr;
	poly_word_u a_data;
	poly_word_u b_hi_data;
	poly_word_u b_lo_data;
	poly_word_u c_rdata;
	mem_wr_t c_wr;

	polymul_wb_slave u_slave (
		.clk(clk),
		.rst_b(rst_b),
		.req(req),
		.rsp(rsp),
		.a_wr(a_wr),
		.b_wr(b_wr),
		.host_raddr(host_raddr),
		.a_rdata(host_a_rdata),
		.c_rdata(host_c_rdata),
		.start(start),
		.busy(busy),
		.finish(finish)
	);

	polymul_seq u_seq (
		.clk(clk),
		.rst_b(rst_b),
		.start(start),
		.busy(busy),
		.finish(finish),
		.a_addr(a_addr),
		.b_hi_addr(b_hi_addr),
		.b_lo_addr(b_lo_addr),
		.c_raddr(c_raddr),
		.a_data(a_data),
		.b_hi_data(b_hi_data),
		.b_lo_data(b_lo_data),
		.c_rdata(c_rdata),
		.c_wr(c_wr)
	);

	// ----------------------------------------
	// operand and result memories
	// ----------------------------------------
	polymul_mem mem_a (
		.clk(clk), .wr(a_wr),
		.raddr0(a_addr), .rdata0(a_data),
		.raddr1(host_raddr), .rdata1(host_a_rdata)
	);

	polymul_mem mem_b (  // both ports feed the B window
		.clk(clk), .wr(b_wr),
		.raddr0(b_hi_addr), .rdata0(b_hi_data),
		.raddr1(b_lo_addr), .rdata1(b_lo_data)
	);

	polymul_mem mem_c (
		.clk(clk), .wr(c_wr),
		.raddr0(c_raddr), .rdata0(c_rdata),
		.raddr1(host_raddr), .rdata1(host_c_rdata)
	);

endmodule

// File: verilog/polymul_wb_slave.sv
module polymul_wb_slave (
	input logic clk,
	input logic rst_b,
	input polymul_pkg::wb_req_t req,
	output polymul_pkg::wb_rsp_t rsp,
	output polymul_pkg::mem_wr_t a_wr,
	output polymul_pkg::mem_wr_t b_wr,
	output logic [polymul_pkg::ADDR_W-1:0] host_raddr,
	input polymul_pkg::poly_word_u a_rdata,
	input polymul_pkg::poly_word_u c_rdata,
	output logic start,
	input logic busy,
	input logic finish
);

	import polymul_pkg::*;

	logic [1:0] region;
	logic [ADDR_W-1:0] word;
	logic hit;                     // new request, not yet acked
	logic wr_hit;
	logic locked;                  // run pending or active
	logic done;
	logic ack;
	logic [WORD_W-1:0] rdat;
	logic [WORD_W-1:0] rd_mux;
	logic [WORD_W-1:0] status;

	// write port payload shared by A and B
	logic a_en;
	logic b_en;
	logic [ADDR_W-1:0] wr_addr;
	poly_word_u wr_data;

	assign region = req.adr[BUS_ADR_W-1 -: 2];
	assign word = req.adr[ADDR_W-1:0];
	assign hit = req.cyc & req.stb & ~ack;
	assign wr_hit = hit & req.we;
	assign locked = busy | start;

	assign host_raddr = word;

	// ----------------------------------------
	// read data select
	// ----------------------------------------
	always_comb begin
		status = '0;
		status[STAT_BUSY] = busy;
		status[STAT_DONE] = done;
		case (region)
			REGION_A: rd_mux = a_rdata.raw;
			REGION_C: rd_mux = c_rdata.raw;
			REGION_CTRL: rd_mux = status;
			default: rd_mux = '0;  // B is write only
		endcase
	end

	// ----------------------------------------
	// ack, writes, start and done
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			ack <= 1'b0;
			a_en <= 1'b0;
			b_en <= 1'b0;
			start <= 1'b0;
			done <= 1'b0;
		end else begin
			ack <= hit;
			a_en <= wr_hit && region == REGION_A && !locked;
			b_en <= wr_hit && region == REGION_B && !locked;
			start <= wr_hit && region == REGION_CTRL && !locked;
			if (start)
				done <= 1'b0;
			else if (finish)
				done <= 1'b1;
		end

		if (hit) begin
			rdat <= rd_mux;
			wr_addr <= word;
			wr_data.raw <= req.dat;
		end
	end

	assign a_wr = '{en: a_en, addr: wr_addr, data: wr_data};
	assign b_wr = '{en: b_en, addr: wr_addr, data: wr_data};

	assign rsp = '{ack: ack, dat: rdat};

endmodule
